// ==== compile.f ====
verilog/uart_pkg.sv
verilog/uart_rx_if.sv
verilog/uart_transmitter.sv
verilog/uart_receiver.sv
verilog/uart_rx_fifo.sv
verilog/uart_regs.sv
verilog/uart_top.sv
tb/tb_uart.sv

// ==== Makefile ====
# Verilator build and run for the UART testbench

VERILATOR ?= verilator
TOP ?= tb_uart
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation completed successfully

.PHONY: sim clean

# Fails unless the pass line shows up in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/tb_uart.sv ====
// ============================================================
// UART testbench
// Wishbone bus tasks, serial line driver and tx monitor;
// directed tests for status, framing, loopback, frame error
// and receive overrun
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module tb_uart;
	import uart_pkg::*;

	localparam logic [31:0] BASE_ADDRESS = 32'h0;
	localparam int BAUD_DIVIDE = 2;
	localparam int RX_FIFO_DEPTH = 8;
	localparam int BIT_CLOCKS = 8 * BAUD_DIVIDE;
	localparam logic [31:0] STATUS_ADDR = BASE_ADDRESS + 32'(STATUS_OFFSET);
	localparam logic [31:0] RX_ADDR = BASE_ADDRESS + 32'(RX_OFFSET);
	localparam logic [31:0] TX_ADDR = BASE_ADDRESS + 32'(TX_OFFSET);
	// Timeouts, in clocks or status polls
	localparam int ACK_TIMEOUT = 16;
	localparam int EDGE_TIMEOUT = 64;
	localparam int POLL_LIMIT = 400;

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic uart_tx;
	logic uart_rx;
	// Line source select and the driver's own line level
	logic loopback;
	logic drive_line;

	integer seed;
	int errors;
	int tests_run;
	int tests_failed;
	int test_start_errors;

	assign uart_rx = loopback ? uart_tx : drive_line;

	uart_top #(
		.BASE_ADDRESS(BASE_ADDRESS),
		.BAUD_DIVIDE(BAUD_DIVIDE),
		.RX_FIFO_DEPTH(RX_FIFO_DEPTH)) DUT (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.uart_tx(uart_tx),
		.uart_rx(uart_rx));

	// 4 ns clock
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("ERROR: %s", msg);
		errors++;
	endtask

	task automatic expect_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic start_test();
		test_start_errors = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_start_errors)
		begin
			tests_failed++;
			$display("test %s: FAIL (%0d errors)", name, errors - test_start_errors);
		end
		else
			$display("test %s: PASS", name);
	endtask

	// One Wishbone classic access, ack expected on the first edge after the request
	task automatic bus_cycle(input logic we, input logic [31:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int cycles;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_w <= wdata;
		// Sample on the falling edge, away from the DUT's updates
		// Request cycle first, ack must still be low here
		@(negedge clk);
		cycles = 0;
		while (!wb_ack && cycles < ACK_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		rdata = wb_dat_r;
		if (!wb_ack)
			report_failure("timeout waiting for wb_ack");
		else if (cycles != 1)
			report_failure($sformatf("wb_ack came %0d cycles after the request", cycles));
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		@(negedge clk);
		if (wb_ack)
			report_failure("wb_ack stayed high for more than one cycle");
	endtask

	task automatic wb_write(input logic [31:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [31:0] adr, output logic [31:0] data);
		bus_cycle(1'b0, adr, 32'h0, data);
	endtask

	// Poll status until one bit is set
	task automatic wait_status(input int bit_index, input string name,
		output uart_reg_word_t word);
		int polls;
		logic [31:0] rdata;
		polls = 0;
		rdata = '0;
		while (!rdata[bit_index] && polls < POLL_LIMIT)
		begin
			wb_read(STATUS_ADDR, rdata);
			polls++;
		end
		word = rdata;
		if (!rdata[bit_index])
			report_failure($sformatf("timeout waiting for status %s", name));
	endtask

	// Drives one 8N1 frame on the line, then one idle bit time
	task automatic send_serial(input logic [7:0] ch, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, ch, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			drive_line <= frame[i];
			repeat (BIT_CLOCKS - 1) @(posedge clk);
		end
		@(posedge clk);
		drive_line <= 1'b1;
		repeat (BIT_CLOCKS - 1) @(posedge clk);
	endtask

	// Mid-bit samples of one frame on uart_tx, bit 0 is the start bit
	task automatic capture_frame(output logic [9:0] bits);
		int waited;
		waited = 0;
		bits = '1;
		while (uart_tx && waited < EDGE_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (uart_tx)
			report_failure("timeout waiting for a start bit on uart_tx");
		else
		begin
			repeat (BIT_CLOCKS / 2) @(negedge clk);
			for (int i = 0; i < 10; i++)
			begin
				if (i > 0)
					repeat (BIT_CLOCKS) @(negedge clk);
				bits[i] = uart_tx;
			end
			// Half a bit more reaches the end of the stop bit
			repeat (BIT_CLOCKS / 2) @(negedge clk);
		end
	endtask

	task automatic status_after_reset();
		logic [31:0] rdata;
		uart_reg_word_t word;
		start_test();
		wb_read(STATUS_ADDR, rdata);
		word = rdata;
		expect_equal("status.tx_ready", word.status.tx_ready, 1);
		expect_equal("status.rx_available", word.status.rx_available, 0);
		expect_equal("status.overrun", word.status.overrun, 0);
		expect_equal("status.frame_error", word.status.frame_error, 0);
		finish_test("reset status");
	endtask

	task automatic transmit_framing();
		logic [7:0] ch;
		logic [9:0] bits;
		logic [31:0] rdata;
		uart_reg_word_t word;
		start_test();
		ch = 8'($random(seed));
		fork
			begin
				wb_write(TX_ADDR, {24'h0, ch});
				wb_read(STATUS_ADDR, rdata);
				word = rdata;
				expect_equal("status.tx_ready", word.status.tx_ready, 0);
			end
			capture_frame(bits);
		join
		// Start low, data LSB first, stop high
		expect_equal("uart_tx start bit", {31'h0, bits[0]}, 32'h0);
		expect_equal("uart_tx data bits", {24'h0, bits[8:1]}, {24'h0, ch});
		expect_equal("uart_tx stop bit", {31'h0, bits[9]}, 32'h1);
		wb_read(STATUS_ADDR, rdata);
		word = rdata;
		expect_equal("status.tx_ready", word.status.tx_ready, 1);
		finish_test("transmit framing");
	endtask

	task automatic loopback_chars();
		logic [7:0] ch;
		logic [31:0] rdata;
		uart_reg_word_t word;
		start_test();
		@(posedge clk);
		loopback <= 1'b1;
		for (int n = 0; n < 4; n++)
		begin
			ch = 8'($random(seed));
			wait_status(0, "tx_ready", word);
			wb_write(TX_ADDR, {24'h0, ch});
			wait_status(1, "rx_available", word);
			expect_equal("status.frame_error", word.status.frame_error, 0);
			wb_read(RX_ADDR, rdata);
			word = rdata;
			expect_equal("rx.data", word.rx.data, ch);
		end
		// Line back to the driver once the transmitter is idle
		wait_status(0, "tx_ready", word);
		@(posedge clk);
		loopback <= 1'b0;
		finish_test("loopback");
	endtask

	task automatic frame_error_flag();
		logic [7:0] ch;
		logic [31:0] rdata;
		uart_reg_word_t word;
		start_test();
		ch = 8'($random(seed));
		send_serial(ch, 1'b0);
		wait_status(1, "rx_available", word);
		expect_equal("status.frame_error", word.status.frame_error, 1);
		wb_read(RX_ADDR, rdata);
		word = rdata;
		expect_equal("rx.data", word.rx.data, ch);
		finish_test("frame error");
	endtask

	task automatic receive_overrun();
		logic [7:0] chars[9];
		logic [31:0] rdata;
		uart_reg_word_t word;
		start_test();
		for (int n = 0; n < 9; n++)
		begin
			chars[n] = 8'($random(seed));
			send_serial(chars[n], 1'b1);
		end
		wait_status(1, "rx_available", word);
		expect_equal("status.overrun", word.status.overrun, 1);
		// Queue keeps RX_FIFO_DEPTH - 1, the two oldest are gone
		for (int n = 2; n < 9; n++)
		begin
			wb_read(RX_ADDR, rdata);
			word = rdata;
			expect_equal("rx.data", word.rx.data, chars[n]);
			if (n == 2)
			begin
				wb_read(STATUS_ADDR, rdata);
				word = rdata;
				expect_equal("status.overrun", word.status.overrun, 0);
			end
		end
		wb_read(STATUS_ADDR, rdata);
		word = rdata;
		expect_equal("status.rx_available", word.status.rx_available, 0);
		finish_test("overrun");
	endtask

	initial
	begin
		seed = 32'hfd41;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_start_errors = 0;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		loopback = 1'b0;
		drive_line = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		status_after_reset();
		transmit_framing();
		loopback_chars();
		frame_error_flag();
		receive_overrun();

		$display("tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/uart_top.sv ====
// ============================================================
// UART top level
// Wishbone serial port: transmitter, receive path and
// register block
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module uart_top
	#(parameter logic [31:0] BASE_ADDRESS = 32'h0,
	parameter int BAUD_DIVIDE = 4,
	parameter int RX_FIFO_DEPTH = 8)
	(input wire clk,
	input wire reset,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire logic [31:0] wb_adr,
	input wire logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	output logic uart_tx,
	input wire uart_rx);

	import uart_pkg::*;

	// Transmit side
	logic tx_start;
	logic tx_ready;
	logic [CHAR_WIDTH-1:0] tx_char;

	// Receive queue to register block
	uart_rx_if rx_bus();

	uart_transmitter #(.BAUD_DIVIDE(BAUD_DIVIDE)) transmitter (
		.clk(clk),
		.reset(reset),
		.tx_start(tx_start),
		.tx_char(tx_char),
		.tx_ready(tx_ready),
		.uart_tx(uart_tx));

	uart_rx_fifo #(
		.BAUD_DIVIDE(BAUD_DIVIDE),
		.RX_FIFO_DEPTH(RX_FIFO_DEPTH)) rx_path (
		.clk(clk),
		.reset(reset),
		.uart_rx(uart_rx),
		.rx_if(rx_bus.fifo_side));

	uart_regs #(.BASE_ADDRESS(BASE_ADDRESS)) regs (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.tx_ready(tx_ready),
		.tx_start(tx_start),
		.tx_char(tx_char),
		.rx_if(rx_bus.reg_side));

endmodule

`default_nettype wire

// ==== verilog/uart_regs.sv ====
// ============================================================
// UART register block
// Wishbone classic slave with status, receive and transmit
// registers; never stalls, ack one cycle after the request
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module uart_regs
	#(parameter logic [31:0] BASE_ADDRESS = 32'h0)
	(input wire clk,
	input wire reset,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire logic [31:0] wb_adr,
	input wire logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	input wire tx_ready,
	output logic tx_start,
	output logic [uart_pkg::CHAR_WIDTH-1:0] tx_char,
	uart_rx_if.reg_side rx_if);

	import uart_pkg::*;

	localparam logic [31:0] STATUS_ADDR = BASE_ADDRESS + 32'(STATUS_OFFSET);
	localparam logic [31:0] RX_ADDR = BASE_ADDRESS + 32'(RX_OFFSET);
	localparam logic [31:0] TX_ADDR = BASE_ADDRESS + 32'(TX_OFFSET);

	logic request;
	logic hit_status;
	logic hit_rx;
	logic hit_tx;
	uart_reg_word_t read_word;

	// New request, not the held one being acked
	assign request = wb_cyc && wb_stb && !wb_ack;

	assign hit_status = wb_adr == STATUS_ADDR;
	assign hit_rx = wb_adr == RX_ADDR;
	assign hit_tx = wb_adr == TX_ADDR;

	// Read mux, unmapped offsets read as zero
	always_comb
	begin
		read_word = '0;
		if (hit_status)
		begin
			read_word.status.tx_ready = tx_ready;
			read_word.status.rx_available = !rx_if.empty;
			read_word.status.overrun = rx_if.overrun;
			read_word.status.frame_error = rx_if.frame_error;
		end
		else if (hit_rx)
			read_word.rx.data = rx_if.char;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb_ack <= 1'b0;
			tx_start <= 1'b0;
			rx_if.pop <= 1'b0;
		end
		else
		begin
			wb_ack <= request;
			// Write while busy is dropped
			tx_start <= request && wb_we && hit_tx && tx_ready;
			// Pop lands in the ack cycle
			rx_if.pop <= request && !wb_we && hit_rx && !rx_if.empty;
		end
	end

	// Read data and transmit character
	always_ff @(posedge clk)
	begin
		if (request && !wb_we)
			wb_dat_r <= read_word;
		if (request && wb_we && hit_tx)
			tx_char <= wb_dat_w[CHAR_WIDTH-1:0];
	end

	// Classic master holds the request steady until it sees ack
	assert property (@(posedge clk) disable iff (reset)
		request |=> wb_cyc && wb_stb && $stable(wb_we) && $stable(wb_adr))
		else $error("Wishbone request dropped or changed before ack");

endmodule

`default_nettype wire

// ==== verilog/uart_rx_fifo.sv ====
// ============================================================
// UART receive path
// Receiver plus a character queue of 9-bit entries; when the
// queue is at its limit the oldest entry is dropped
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo
	#(parameter int BAUD_DIVIDE = 4,
	parameter int RX_FIFO_DEPTH = 8)
	(input wire clk,
	input wire reset,
	input wire uart_rx,
	uart_rx_if.fifo_side rx_if);

	import uart_pkg::*;

	localparam int PTR_W = $clog2(RX_FIFO_DEPTH);
	localparam logic [PTR_W:0] MAX_COUNT = (PTR_W + 1)'(RX_FIFO_DEPTH - 1);

	logic [CHAR_WIDTH-1:0] rx_char;
	logic rx_valid;
	logic rx_frame_error;

	// Entry is {frame_error, char}
	logic [CHAR_WIDTH:0] entries[RX_FIFO_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0] count;
	logic overrun;
	logic do_pop;
	logic drop_oldest;
	logic advance_rd;

	uart_receiver #(.BAUD_DIVIDE(BAUD_DIVIDE)) receiver (
		.clk(clk),
		.reset(reset),
		.uart_rx(uart_rx),
		.rx_char(rx_char),
		.rx_valid(rx_valid),
		.rx_frame_error(rx_frame_error));

	assign do_pop = rx_if.pop && count != '0;
	// A pop in the same cycle frees the slot, nothing is lost
	assign drop_oldest = rx_valid && count == MAX_COUNT && !do_pop;
	assign advance_rd = do_pop || drop_oldest;

	always_ff @(posedge clk)
	begin
		if (rx_valid)
			entries[wr_ptr] <= {rx_frame_error, rx_char};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			overrun <= 1'b0;
		end
		else
		begin
			// Pointers wrap on the power of two depth
			if (rx_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (advance_rd)
				rd_ptr <= rd_ptr + 1'b1;

			if (rx_valid && !advance_rd)
				count <= count + 1'b1;
			else if (!rx_valid && advance_rd)
				count <= count - 1'b1;

			// Cleared by a data read, set on a dropped character
			if (rx_if.pop)
				overrun <= 1'b0;
			if (drop_oldest)
				overrun <= 1'b1;
		end
	end

	assign rx_if.char = entries[rd_ptr][CHAR_WIDTH-1:0];
	assign rx_if.frame_error = entries[rd_ptr][CHAR_WIDTH];
	assign rx_if.empty = count == '0;
	assign rx_if.overrun = overrun;

	assert property (@(posedge clk) disable iff (reset) count <= MAX_COUNT)
		else $error("receive queue count above limit");

	// Register block gates its pop with empty
	assert property (@(posedge clk) disable iff (reset) rx_if.pop |-> !rx_if.empty)
		else $error("pop from empty receive queue");

endmodule

`default_nettype wire

// ==== verilog/uart_receiver.sv ====
// ============================================================
// UART receiver
// Oversamples the line 8 times per bit, confirms the start
// bit at mid-bit and samples data and stop bits at mid-bit
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module uart_receiver
	#(parameter int BAUD_DIVIDE = 4)
	(input wire clk,
	input wire reset,
	input wire uart_rx,
	output logic [uart_pkg::CHAR_WIDTH-1:0] rx_char,
	output logic rx_valid,
	output logic rx_frame_error);

	import uart_pkg::*;

	localparam int DIV_W = $clog2(BAUD_DIVIDE + 1);
	localparam logic [DIV_W-1:0] LAST_DIV = DIV_W'(BAUD_DIVIDE - 1);
	localparam int BIT_W = $clog2(CHAR_WIDTH);

	// Receive states
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_START = 2'd1;
	localparam logic [1:0] S_DATA = 2'd2;
	localparam logic [1:0] S_STOP = 2'd3;

	logic rx_meta;
	logic rx_sync;
	logic rx_last;
	logic [DIV_W-1:0] div_count;
	logic sample_tick;
	logic [1:0] state;
	logic [2:0] sample_count;
	logic [BIT_W-1:0] bit_count;

	// Two-flop synchronizer, idle level is high
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
		end
	end

	// 1/8 bit sample tick
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			div_count <= '0;
		else if (div_count == LAST_DIV)
			div_count <= '0;
		else
			div_count <= div_count + 1'b1;
	end

	assign sample_tick = div_count == LAST_DIV;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			rx_last <= 1'b1;
			sample_count <= '0;
			bit_count <= '0;
			rx_valid <= 1'b0;
			rx_frame_error <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;
			if (sample_tick)
			begin
				rx_last <= rx_sync;
				case (state)
					S_IDLE:
					begin
						// Falling edge only, a stuck low line is ignored
						if (rx_last && !rx_sync)
						begin
							state <= S_START;
							sample_count <= '0;
						end
					end

					S_START:
					begin
						if (sample_count == 3'd3)
						begin
							// Glitch if the line is high again at mid-bit
							state <= rx_sync ? S_IDLE : S_DATA;
							sample_count <= '0;
							bit_count <= '0;
						end
						else
							sample_count <= sample_count + 3'd1;
					end

					S_DATA:
					begin
						sample_count <= sample_count + 3'd1;
						if (sample_count == 3'd7)
						begin
							bit_count <= bit_count + 1'b1;
							if (bit_count == BIT_W'(CHAR_WIDTH - 1))
								state <= S_STOP;
						end
					end

					S_STOP:
					begin
						sample_count <= sample_count + 3'd1;
						if (sample_count == 3'd7)
						begin
							rx_valid <= 1'b1;
							rx_frame_error <= !rx_sync;
							state <= S_IDLE;
						end
					end
				endcase
			end
		end
	end

	// Data shift, LSB arrives first
	always_ff @(posedge clk)
	begin
		if (sample_tick && state == S_DATA && sample_count == 3'd7)
			rx_char <= {rx_sync, rx_char[CHAR_WIDTH-1:1]};
	end

endmodule

`default_nettype wire

// ==== verilog/uart_transmitter.sv ====
// ============================================================
// UART transmitter
// Shifts out one 8N1 character: start bit, 8 data bits LSB
// first, stop bit, each 8 x BAUD_DIVIDE clocks long
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter
	#(parameter int BAUD_DIVIDE = 4)
	(input wire clk,
	input wire reset,
	input wire tx_start,
	input wire logic [uart_pkg::CHAR_WIDTH-1:0] tx_char,
	output logic tx_ready,
	output logic uart_tx);

	import uart_pkg::*;

	localparam int BIT_TICKS = 8 * BAUD_DIVIDE;
	localparam int TICK_W = $clog2(BIT_TICKS);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(BIT_TICKS - 1);
	localparam int FRAME_BITS = CHAR_WIDTH + 2;

	logic [TICK_W-1:0] tick_count;
	logic [3:0] bits_left;
	logic [FRAME_BITS-1:0] shift;
	logic active;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// All ones keeps the line idle high
			shift <= '1;
			active <= 1'b0;
			tick_count <= '0;
			bits_left <= '0;
		end
		else if (tx_start && !active)
		begin
			// Stop, data, start; start bit goes out first
			shift <= {1'b1, tx_char, 1'b0};
			active <= 1'b1;
			tick_count <= '0;
			bits_left <= 4'(FRAME_BITS);
		end
		else if (active)
		begin
			if (tick_count == LAST_TICK)
			begin
				tick_count <= '0;
				// Fill with idle level behind the frame
				shift <= {1'b1, shift[FRAME_BITS-1:1]};
				bits_left <= bits_left - 4'd1;

				// Last bit time is the stop bit
				if (bits_left == 4'd1)
					active <= 1'b0;
			end
			else
				tick_count <= tick_count + 1'b1;
		end
	end

	assign uart_tx = shift[0];
	assign tx_ready = !active;

	// Register block must hold off writes while a frame is in flight
	assert property (@(posedge clk) disable iff (reset) tx_start |-> tx_ready)
		else $error("tx_start while transmitter busy");

endmodule

`default_nettype wire

// ==== verilog/uart_rx_if.sv ====
// ============================================================
// UART receive queue interface
// Head character, its flags and the pop request between
// the receive path and the register block
// ============================================================
`timescale 1ns/1ps
`default_nettype none

interface uart_rx_if;
	import uart_pkg::*;

	// Head of queue
	logic [CHAR_WIDTH-1:0] char;
	logic frame_error;
	logic empty;
	logic overrun;

	// One-cycle request from the bus side
	logic pop;

	modport fifo_side (output char, frame_error, empty, overrun, input pop);
	modport reg_side (input char, frame_error, empty, overrun, output pop);

endinterface

`default_nettype wire

// ==== verilog/uart_pkg.sv ====
// ============================================================
// UART shared definitions
// Register offsets, character width and the register word
// layouts seen on the Wishbone read data bus
// ============================================================
`default_nettype none

package uart_pkg;

	// Byte offsets from the base address
	localparam int STATUS_OFFSET = 0;
	localparam int RX_OFFSET = 4;
	localparam int TX_OFFSET = 8;

	// One serial character, 8N1
	localparam int CHAR_WIDTH = 8;
	localparam int REG_WIDTH = 32;

	// Status register view, bit 0 at the bottom
	typedef struct packed {
		logic [REG_WIDTH-5:0] reserved;
		logic frame_error;
		logic overrun;
		logic rx_available;
		logic tx_ready;
	} uart_status_t;

	// Receive data view
	typedef struct packed {
		logic [REG_WIDTH-CHAR_WIDTH-1:0] reserved;
		logic [CHAR_WIDTH-1:0] data;
	} uart_rx_word_t;

	// Same read word, decoded by address
	typedef union packed {
		uart_status_t status;
		uart_rx_word_t rx;
	} uart_reg_word_t;

endpackage

`default_nettype wire
